// File: common/quiz_defs.svh
`ifndef QUIZ_DEFS_SVH
`define QUIZ_DEFS_SVH

// operand, switch and answer width
`define QUIZ_DATA_W 8

// one segment byte, a..g from the msb down, then dp
`define QUIZ_SEG_W 8

`define QUIZ_DIGITS 8

// pacing period, half a second at 50 MHz
`define QUIZ_TICK_DIV 25000000

// cycles each digit stays lit
`define QUIZ_SCAN_DIV 10000

// tallies stop counting here
`define QUIZ_TALLY_MAX 99

`endif

// File: common/quiz_pkg.sv
`include "quiz_defs.svh"

package quiz_pkg;

    typedef enum logic [1:0] {
        MODE_SHIFT   = 2'd0,  // shown as 1
        MODE_BITWISE = 2'd1,
        MODE_LOGIC   = 2'd2
    } quiz_mode_e;

    typedef enum logic [1:0] {
        OP_1 = 2'd0,
        OP_2 = 2'd1,
        OP_3 = 2'd2,
        OP_4 = 2'd3
    } quiz_op_e;

    typedef enum logic [2:0] {
        STAGE_IDLE,
        STAGE_ENTER_A,
        STAGE_ENTER_B,
        STAGE_ENTER_ANSWER,
        STAGE_SHOW_RESULT
    } quiz_stage_e;

    typedef struct packed {
        logic confirm;
        logic exit;
        logic select;
        logic stats;
    } button_cmd_t;

    typedef struct packed {
        quiz_mode_e             mode;
        quiz_op_e               op;
        logic [`QUIZ_DATA_W-1:0] a;
        logic [`QUIZ_DATA_W-1:0] b;
    } question_t;

    typedef struct packed {
        logic        entered;    // inside a quiz mode
        logic        stats_on;   // statistics view shown
        quiz_stage_e stage;
        quiz_mode_e  view_mode;  // mode picked in the view
    } quiz_view_t;

    typedef struct packed {
        logic [6:0] total;
        logic [6:0] correct;
    } tally_t;

    // prompt and verdict glyphs
    localparam logic [`QUIZ_SEG_W-1:0] GLYPH_A_LOW = 8'b0011_1010;
    localparam logic [`QUIZ_SEG_W-1:0] GLYPH_B_LOW = 8'b0011_1110;
    localparam logic [`QUIZ_SEG_W-1:0] GLYPH_R_LOW = 8'b1000_1100;
    localparam logic [`QUIZ_SEG_W-1:0] GLYPH_A_UP  = 8'b1110_1110;
    localparam logic [`QUIZ_SEG_W-1:0] GLYPH_E_UP  = 8'b1001_1110;

    function automatic logic [`QUIZ_SEG_W-1:0] seg_digit(input logic [3:0] value);
        case (value)
            4'd0:    return 8'b1111_1100;
            4'd1:    return 8'b0110_0000;
            4'd2:    return 8'b1101_1010;
            4'd3:    return 8'b1111_0010;
            4'd4:    return 8'b0110_0110;
            4'd5:    return 8'b1011_0110;
            4'd6:    return 8'b1011_1110;
            4'd7:    return 8'b1110_0000;
            4'd8:    return 8'b1111_1110;
            4'd9:    return 8'b1111_0110;
            default: return '0;  // blank
        endcase
    endfunction

endpackage

// File: hw/button_pacer.sv
`timescale 1ns/100ps

module button_pacer #(
    parameter int TICK_DIV = 25000000
) (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  confirm,
    input  logic                  exit,
    input  logic                  select,
    input  logic                  stats,
    output quiz_pkg::button_cmd_t cmd
);

    localparam int CNT_W = $clog2(TICK_DIV + 1);

    logic [CNT_W-1:0] tick_cnt;
    logic             tick;

    assign tick = (tick_cnt == CNT_W'(TICK_DIV - 1));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tick_cnt <= '0;
        end else if (tick) begin
            tick_cnt <= '0;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    // a held button is seen on exactly one tick per period
    assign cmd.confirm = tick & confirm;
    assign cmd.exit    = tick & exit;
    assign cmd.select  = tick & select;
    assign cmd.stats   = tick & stats;

endmodule

// File: quiz/quiz_control.sv
`timescale 1ns/100ps
`include "quiz_defs.svh"

module quiz_control (
    input  logic                    clk,
    input  logic                    arst_n,
    input  quiz_pkg::button_cmd_t   cmd,
    input  logic [`QUIZ_DATA_W-1:0] switches,
    output quiz_pkg::question_t     question,
    output quiz_pkg::quiz_view_t    view,
    output logic                    check_pulse,
    output logic [`QUIZ_DATA_W-1:0] answer
);

    quiz_pkg::question_t     question_q;
    quiz_pkg::quiz_view_t    view_q;
    logic [`QUIZ_DATA_W-1:0] answer_q;
    logic                    check_q;

    // 1 -> 2 -> 3 -> 1
    function automatic quiz_pkg::quiz_mode_e next_mode(input quiz_pkg::quiz_mode_e m);
        if (m == quiz_pkg::MODE_LOGIC) begin
            return quiz_pkg::MODE_SHIFT;
        end
        return quiz_pkg::quiz_mode_e'(m + 2'd1);
    endfunction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            question_q <= '0;  // shift mode, op 1
            view_q     <= '0;  // not entered, idle, view off
            answer_q   <= '0;
            check_q    <= 1'b0;
        end else begin
            check_q <= 1'b0;

            if (cmd.stats) begin
                view_q.stats_on <= !view_q.stats_on;
            end

            if (view_q.stats_on) begin
                // confirm and exit are dead while the view is up
                if (cmd.select) begin
                    view_q.view_mode <= next_mode(view_q.view_mode);
                end
            end else if (!view_q.entered) begin
                if (cmd.select) begin
                    question_q.mode <= next_mode(question_q.mode);
                end
                if (cmd.confirm) begin
                    view_q.entered <= 1'b1;
                    view_q.stage   <= quiz_pkg::STAGE_IDLE;
                end
            end else if (cmd.exit) begin
                view_q.entered <= 1'b0;
                view_q.stage   <= quiz_pkg::STAGE_IDLE;
            end else begin
                if (cmd.select && view_q.stage == quiz_pkg::STAGE_IDLE) begin
                    question_q.op <= quiz_pkg::quiz_op_e'(question_q.op + 2'd1);  // wraps 4 -> 1
                end
                if (cmd.confirm) begin
                    case (view_q.stage)
                        quiz_pkg::STAGE_IDLE: begin
                            view_q.stage <= quiz_pkg::STAGE_ENTER_A;
                        end
                        quiz_pkg::STAGE_ENTER_A: begin
                            question_q.a <= switches;
                            view_q.stage <= quiz_pkg::STAGE_ENTER_B;
                        end
                        quiz_pkg::STAGE_ENTER_B: begin
                            question_q.b <= switches;
                            view_q.stage <= quiz_pkg::STAGE_ENTER_ANSWER;
                        end
                        quiz_pkg::STAGE_ENTER_ANSWER: begin
                            answer_q     <= switches;
                            check_q      <= 1'b1;  // tally grades next cycle
                            view_q.stage <= quiz_pkg::STAGE_SHOW_RESULT;
                        end
                        default: begin
                            view_q.stage <= quiz_pkg::STAGE_IDLE;
                        end
                    endcase
                end
            end
        end
    end

    assign question    = question_q;
    assign view        = view_q;
    assign check_pulse = check_q;
    assign answer      = answer_q;

endmodule

// File: quiz/answer_unit.sv
`timescale 1ns/100ps
`include "quiz_defs.svh"

module answer_unit (
    input  quiz_pkg::question_t     question,
    output logic [`QUIZ_DATA_W-1:0] result
);

    logic a_nz;
    logic b_nz;

    assign a_nz = (question.a != '0);
    assign b_nz = (question.b != '0);

    always_comb begin
        result = '0;
        case (question.mode)
            quiz_pkg::MODE_SHIFT: begin
                case (question.op)
                    quiz_pkg::OP_1: result = $signed(question.a) <<< question.b;
                    quiz_pkg::OP_2: result = $signed(question.a) >>> question.b;  // sign fill
                    quiz_pkg::OP_3: result = question.a << question.b;
                    default:        result = question.a >> question.b;
                endcase
            end
            quiz_pkg::MODE_BITWISE: begin
                case (question.op)
                    quiz_pkg::OP_1: result = question.a & question.b;
                    quiz_pkg::OP_2: result = question.a | question.b;
                    quiz_pkg::OP_3: result = ~question.a;
                    default:        result = question.a ^ question.b;
                endcase
            end
            quiz_pkg::MODE_LOGIC: begin
                // true is all ones
                case (question.op)
                    quiz_pkg::OP_1: result = {`QUIZ_DATA_W{a_nz && b_nz}};
                    quiz_pkg::OP_2: result = {`QUIZ_DATA_W{a_nz || b_nz}};
                    quiz_pkg::OP_3: result = {`QUIZ_DATA_W{!a_nz}};
                    default:        result = {`QUIZ_DATA_W{a_nz ^ b_nz}};
                endcase
            end
            default: result = '0;
        endcase
    end

endmodule

// File: quiz/quiz_tally.sv
`timescale 1ns/100ps
`include "quiz_defs.svh"

module quiz_tally (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    check_pulse,
    input  quiz_pkg::quiz_mode_e    mode,
    input  logic [`QUIZ_DATA_W-1:0] answer,
    input  logic [`QUIZ_DATA_W-1:0] result,
    output logic                    answer_result,
    output quiz_pkg::tally_t        tally_shift,
    output quiz_pkg::tally_t        tally_bitwise,
    output quiz_pkg::tally_t        tally_logic
);

    localparam logic [6:0] TALLY_MAX = 7'(`QUIZ_TALLY_MAX);

    quiz_pkg::tally_t tally_q [3];  // indexed by mode
    logic             match;

    assign match = (answer == result);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            answer_result <= 1'b0;
            for (int i = 0; i < 3; i++) begin
                tally_q[i] <= '0;
            end
        end else if (check_pulse) begin
            answer_result <= match;  // same polarity for every mode
            for (int i = 0; i < 3; i++) begin
                if (int'(mode) == i) begin
                    if (tally_q[i].total < TALLY_MAX) begin
                        tally_q[i].total <= tally_q[i].total + 7'd1;
                    end
                    if (match && tally_q[i].correct < TALLY_MAX) begin
                        tally_q[i].correct <= tally_q[i].correct + 7'd1;
                    end
                end
            end
        end
    end

    assign tally_shift   = tally_q[0];
    assign tally_bitwise = tally_q[1];
    assign tally_logic   = tally_q[2];

endmodule

// File: display/frame_builder.sv
`timescale 1ns/100ps
`include "quiz_defs.svh"

module frame_builder (
    input  logic                                      clk,
    input  logic                                      arst_n,
    input  quiz_pkg::question_t                       question,
    input  quiz_pkg::quiz_view_t                      view,
    input  logic                                      answer_result,
    input  quiz_pkg::tally_t                          tally_shift,
    input  quiz_pkg::tally_t                          tally_bitwise,
    input  quiz_pkg::tally_t                          tally_logic,
    output logic [`QUIZ_DIGITS-1:0][`QUIZ_SEG_W-1:0] frame
);

    quiz_pkg::tally_t                          sel_tally;
    logic [13:0]                               pct_num;  // up to 99 * 100
    logic [6:0]                                pct;
    logic [`QUIZ_DIGITS-1:0][`QUIZ_SEG_W-1:0] frame_d;

    always_comb begin
        case (view.view_mode)
            quiz_pkg::MODE_BITWISE: sel_tally = tally_bitwise;
            quiz_pkg::MODE_LOGIC:   sel_tally = tally_logic;
            default:                sel_tally = tally_shift;
        endcase
    end

    // floor percentage, 0 when nothing was asked
    assign pct_num = 14'(sel_tally.correct) * 14'd100;
    assign pct     = (sel_tally.total == '0) ? '0 : 7'(pct_num / 14'(sel_tally.total));

    always_comb begin
        frame_d = '0;
        if (view.stats_on) begin
            frame_d[0] = quiz_pkg::seg_digit(4'(view.view_mode) + 4'd1);
            frame_d[2] = quiz_pkg::seg_digit(4'(sel_tally.total / 7'd10));
            frame_d[3] = quiz_pkg::seg_digit(4'(sel_tally.total % 7'd10));
            frame_d[5] = quiz_pkg::seg_digit(4'(pct / 7'd100));
            frame_d[6] = quiz_pkg::seg_digit(4'((pct / 7'd10) % 7'd10));
            frame_d[7] = quiz_pkg::seg_digit(4'(pct % 7'd10));
        end else begin
            frame_d[0] = quiz_pkg::seg_digit(4'(question.mode) + 4'd1);
            if (view.entered) begin
                frame_d[1] = quiz_pkg::seg_digit(4'(question.op) + 4'd1);
                case (view.stage)
                    quiz_pkg::STAGE_ENTER_A: begin
                        frame_d[2] = quiz_pkg::GLYPH_A_LOW;
                    end
                    quiz_pkg::STAGE_ENTER_B: begin
                        frame_d[2] = quiz_pkg::GLYPH_A_LOW;
                        frame_d[3] = quiz_pkg::GLYPH_B_LOW;
                    end
                    quiz_pkg::STAGE_ENTER_ANSWER: begin
                        frame_d[4] = quiz_pkg::GLYPH_R_LOW;  // answer prompt
                    end
                    quiz_pkg::STAGE_SHOW_RESULT: begin
                        frame_d[7] = answer_result ? quiz_pkg::GLYPH_A_UP
                                                   : quiz_pkg::GLYPH_E_UP;
                    end
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            frame <= '0;
        end else begin
            frame <= frame_d;
        end
    end

endmodule

// File: display/digit_scanner.sv
`timescale 1ns/100ps
`include "quiz_defs.svh"

module digit_scanner #(
    parameter int SCAN_DIV = 10000
) (
    input  logic                                      clk,
    input  logic                                      arst_n,
    input  logic [`QUIZ_DIGITS-1:0][`QUIZ_SEG_W-1:0] frame,
    output logic [`QUIZ_DIGITS-1:0]                   anode,
    output logic [`QUIZ_SEG_W-1:0]                    seg_left,
    output logic [`QUIZ_SEG_W-1:0]                    seg_right
);

    localparam int DIV_W = $clog2(SCAN_DIV + 1);

    logic [DIV_W-1:0] div_cnt;
    logic [2:0]       digit;  // wraps after 7 on its own

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            div_cnt <= '0;
            digit   <= '0;
        end else if (div_cnt == DIV_W'(SCAN_DIV - 1)) begin
            div_cnt <= '0;
            digit   <= digit + 3'd1;
        end else begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    assign anode = `QUIZ_DIGITS'(1) << digit;

    // idle bus is blanked
    assign seg_left  = digit[2] ? '0 : frame[digit];
    assign seg_right = digit[2] ? frame[digit] : '0;

endmodule

// File: hw/study_top.sv
`timescale 1ns/100ps
`include "quiz_defs.svh"

module study_top #(
    parameter int TICK_DIV = `QUIZ_TICK_DIV,
    parameter int SCAN_DIV = `QUIZ_SCAN_DIV
) (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    confirm,
    input  logic                    exit,
    input  logic                    select,
    input  logic                    stats,
    input  logic [`QUIZ_DATA_W-1:0] switches,
    output logic                    answer_result,
    output logic [`QUIZ_SEG_W-1:0]  seg_left,
    output logic [`QUIZ_SEG_W-1:0]  seg_right,
    output logic [`QUIZ_DIGITS-1:0] anode
);

    quiz_pkg::button_cmd_t                     cmd;
    quiz_pkg::question_t                       question;
    quiz_pkg::quiz_view_t                      view;
    logic                                      check_pulse;
    logic [`QUIZ_DATA_W-1:0]                   answer;
    logic [`QUIZ_DATA_W-1:0]                   result;
    quiz_pkg::tally_t                          tally_shift;
    quiz_pkg::tally_t                          tally_bitwise;
    quiz_pkg::tally_t                          tally_logic;
    logic [`QUIZ_DIGITS-1:0][`QUIZ_SEG_W-1:0] frame;

    button_pacer #(
        .TICK_DIV (TICK_DIV)
    ) i_button_pacer (
        .clk     (clk),
        .arst_n  (arst_n),
        .confirm (confirm),
        .exit    (exit),
        .select  (select),
        .stats   (stats),
        .cmd     (cmd)
    );

    quiz_control i_quiz_control (
        .clk         (clk),
        .arst_n      (arst_n),
        .cmd         (cmd),
        .switches    (switches),
        .question    (question),
        .view        (view),
        .check_pulse (check_pulse),
        .answer      (answer)
    );

    answer_unit i_answer_unit (
        .question (question),
        .result   (result)
    );

    quiz_tally i_quiz_tally (
        .clk           (clk),
        .arst_n        (arst_n),
        .check_pulse   (check_pulse),
        .mode          (question.mode),
        .answer        (answer),
        .result        (result),
        .answer_result (answer_result),
        .tally_shift   (tally_shift),
        .tally_bitwise (tally_bitwise),
        .tally_logic   (tally_logic)
    );

    frame_builder i_frame_builder (
        .clk           (clk),
        .arst_n        (arst_n),
        .question      (question),
        .view          (view),
        .answer_result (answer_result),
        .tally_shift   (tally_shift),
        .tally_bitwise (tally_bitwise),
        .tally_logic   (tally_logic),
        .frame         (frame)
    );

    digit_scanner #(
        .SCAN_DIV (SCAN_DIV)
    ) i_digit_scanner (
        .clk       (clk),
        .arst_n    (arst_n),
        .frame     (frame),
        .anode     (anode),
        .seg_left  (seg_left),
        .seg_right (seg_right)
    );

endmodule

// File: bench/study_tb.sv
`timescale 1ns/100ps

module study_tb;

    localparam int TICK_DIV   = 4;
    localparam int SCAN_DIV   = 3;
    localparam int NUM_ROWS   = 24;
    localparam int WAIT_LIMIT = 80;  // two scan rounds are 48 cycles

    localparam int BTN_CONFIRM = 0;
    localparam int BTN_EXIT    = 1;
    localparam int BTN_SELECT  = 2;
    localparam int BTN_STATS   = 3;

    // digits 0..9, segment a in the msb
    localparam logic [7:0] SEG_TAB [10] = '{8'hFC, 8'h60, 8'hDA, 8'hF2, 8'h66,
                                            8'hB6, 8'hBE, 8'hE0, 8'hFE, 8'hF6};
    localparam logic [7:0] SEG_A_LOW = 8'h3A;
    localparam logic [7:0] SEG_B_LOW = 8'h3E;
    localparam logic [7:0] SEG_R_LOW = 8'h8C;
    localparam logic [7:0] SEG_A_UP  = 8'hEE;
    localparam logic [7:0] SEG_E_UP  = 8'h9E;

    typedef struct packed {
        logic [1:0] mode;
        logic [1:0] op;
        logic [7:0] a;
        logic [7:0] b;
        logic [7:0] answer;
        logic       verdict;  // answer equals the model result
    } quiz_row_t;

    logic        clk;
    logic        arst_n;
    logic [3:0]  buttons;
    logic [7:0]  switches;
    logic        answer_result;
    logic [7:0]  seg_left;
    logic [7:0]  seg_right;
    logic [7:0]  anode;

    quiz_row_t   quiz_rows [NUM_ROWS];
    logic [31:0] rng;
    int          cur_mode;
    int          cur_op;
    logic        in_mode;
    int          tally_total [3];
    int          tally_correct [3];

    study_top #(
        .TICK_DIV (TICK_DIV),
        .SCAN_DIV (SCAN_DIV)
    ) i_study_top (
        .clk           (clk),
        .arst_n        (arst_n),
        .confirm       (buttons[BTN_CONFIRM]),
        .exit          (buttons[BTN_EXIT]),
        .select        (buttons[BTN_SELECT]),
        .stats         (buttons[BTN_STATS]),
        .switches      (switches),
        .answer_result (answer_result),
        .seg_left      (seg_left),
        .seg_right     (seg_right),
        .anode         (anode)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic logic [7:0] model_result(input int mode, input int op,
                                                input logic [7:0] a, input logic [7:0] b);
        logic [7:0] r;
        logic       t;
        r = a;
        t = 1'b0;
        if (mode == 0) begin
            for (int i = 0; i < int'(b); i++) begin  // one bit position per step
                case (op)
                    1:       r = {r[7], r[7:1]};
                    3:       r = {1'b0, r[7:1]};
                    default: r = {r[6:0], 1'b0};
                endcase
            end
        end else if (mode == 1) begin
            case (op)
                0:       r = a & b;
                1:       r = a | b;
                2:       r = ~a;
                default: r = a ^ b;
            endcase
        end else begin
            case (op)
                0:       t = (a != 8'h00) && (b != 8'h00);
                1:       t = (a != 8'h00) || (b != 8'h00);
                2:       t = (a == 8'h00);
                default: t = (a != 8'h00) != (b != 8'h00);
            endcase
            r = t ? 8'hFF : 8'h00;
        end
        return r;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("FAIL time=%0t %s got=0x%0h expected=0x%0h",
                                $time, name, got, exp));
        end
    endtask

    // hold for one full pacing period, then let the frame settle
    task automatic press(input int btn);
        @(posedge clk);
        #1;
        buttons[btn] = 1'b1;
        repeat (TICK_DIV) @(posedge clk);
        #1;
        buttons[btn] = 1'b0;
        repeat (2) @(posedge clk);
    endtask

    task automatic drive_switches(input logic [7:0] v);
        @(posedge clk);
        #1;
        switches = v;
    endtask

    // sample on the second visit of the digit, past the frame register
    task automatic expect_digit(input int d, input logic [7:0] exp);
        logic [7:0] want;
        logic       prev;
        int         hits;
        int         cnt;
        want = 8'(1 << d);
        hits = 0;
        cnt  = 0;
        @(negedge clk);
        prev = (anode == want);
        while (hits < 2) begin
            if (cnt >= WAIT_LIMIT) begin
                abort_run($sformatf("timeout: anode never selected digit %0d", d));
            end else begin
                @(negedge clk);
                cnt++;
                if (anode == want && !prev) hits++;
                prev = (anode == want);
            end
        end
        if (d < 4) begin
            check_value("seg_right", 32'(seg_right), 32'h0);
            check_value($sformatf("seg_left digit %0d", d), 32'(seg_left), 32'(exp));
        end else begin
            check_value("seg_left", 32'(seg_left), 32'h0);
            check_value($sformatf("seg_right digit %0d", d), 32'(seg_right), 32'(exp));
        end
    endtask

    task automatic expect_mode_only();
        expect_digit(0, SEG_TAB[cur_mode + 1]);
        for (int d = 1; d < 8; d++) expect_digit(d, 8'h00);
    endtask

    task automatic build_table();
        int         m;
        logic [7:0] a;
        logic [7:0] b;
        logic [7:0] res;
        logic [7:0] flip;
        for (int r = 0; r < NUM_ROWS; r++) begin
            m = r / 8;
            rng = xorshift32(rng);
            a = rng[7:0];
            rng = xorshift32(rng);
            b = rng[7:0];
            rng = xorshift32(rng);
            flip = rng[15:8] | 8'h01;  // never zero
            if (m == 0) b = b & 8'h07;  // keep shifts inside the byte
            if (m == 2 && r % 4 == 1) a = 8'h00;
            if (m == 2 && r % 4 == 3) b = 8'h00;
            res = model_result(m, (r / 2) % 4, a, b);
            quiz_rows[r].mode    = 2'(m);
            quiz_rows[r].op      = 2'((r / 2) % 4);
            quiz_rows[r].a       = a;
            quiz_rows[r].b       = b;
            quiz_rows[r].verdict = (r % (m + 2) != 0);  // different score per mode
            quiz_rows[r].answer  = quiz_rows[r].verdict ? res : res ^ flip;
        end
    endtask

    task automatic select_mode(input int m);
        if (in_mode) begin
            press(BTN_EXIT);
            in_mode = 1'b0;
        end
        while (cur_mode != m) begin
            press(BTN_SELECT);
            cur_mode = (cur_mode + 1) % 3;
        end
        expect_digit(0, SEG_TAB[m + 1]);
        press(BTN_CONFIRM);
        in_mode = 1'b1;
    endtask

    task automatic run_row(input quiz_row_t row);
        int m;
        m = int'(row.mode);
        while (cur_op != int'(row.op)) begin
            press(BTN_SELECT);
            cur_op = (cur_op + 1) % 4;
        end
        expect_digit(1, SEG_TAB[cur_op + 1]);
        press(BTN_CONFIRM);
        expect_digit(2, SEG_A_LOW);
        drive_switches(row.a);
        press(BTN_CONFIRM);
        expect_digit(2, SEG_A_LOW);
        expect_digit(3, SEG_B_LOW);
        drive_switches(row.b);
        press(BTN_CONFIRM);
        expect_digit(4, SEG_R_LOW);
        drive_switches(row.answer);
        press(BTN_CONFIRM);
        @(negedge clk);
        check_value("answer_result", 32'(answer_result), 32'(row.verdict));
        expect_digit(7, row.verdict ? SEG_A_UP : SEG_E_UP);
        press(BTN_CONFIRM);
        expect_digit(7, 8'h00);  // back in idle
        if (tally_total[m] < 99) tally_total[m]++;
        if (row.verdict && tally_correct[m] < 99) tally_correct[m]++;
    endtask

    task automatic check_stats(input int m);
        int pct;
        pct = (tally_total[m] == 0) ? 0 : tally_correct[m] * 100 / tally_total[m];
        expect_digit(0, SEG_TAB[m + 1]);
        expect_digit(1, 8'h00);
        expect_digit(2, SEG_TAB[tally_total[m] / 10]);
        expect_digit(3, SEG_TAB[tally_total[m] % 10]);
        expect_digit(4, 8'h00);
        expect_digit(5, SEG_TAB[pct / 100]);
        expect_digit(6, SEG_TAB[(pct / 10) % 10]);
        expect_digit(7, SEG_TAB[pct % 10]);
    endtask

    initial begin
        arst_n   = 1'b0;
        buttons  = 4'h0;
        switches = 8'h00;
        rng      = 32'd91861;
        cur_mode = 0;
        cur_op   = 0;
        in_mode  = 1'b0;
        for (int i = 0; i < 3; i++) begin
            tally_total[i]   = 0;
            tally_correct[i] = 0;
        end
        build_table();
        repeat (10) @(posedge clk);
        #1;
        arst_n = 1'b1;

        expect_mode_only();
        @(negedge clk);
        check_value("answer_result", 32'(answer_result), 32'h0);

        for (int i = 1; i <= 3; i++) begin  // mode 1, 2, 3, 1
            press(BTN_SELECT);
            expect_digit(0, SEG_TAB[(i % 3) + 1]);
        end
        press(BTN_CONFIRM);
        in_mode = 1'b1;
        for (int i = 1; i <= 4; i++) begin  // operator 1..4, 1
            press(BTN_SELECT);
            expect_digit(1, SEG_TAB[(i % 4) + 1]);
        end

        for (int r = 0; r < NUM_ROWS; r++) begin
            if (!in_mode || cur_mode != int'(quiz_rows[r].mode)) begin
                select_mode(int'(quiz_rows[r].mode));
            end
            run_row(quiz_rows[r]);
        end

        press(BTN_EXIT);
        in_mode = 1'b0;
        press(BTN_STATS);
        check_stats(0);
        for (int i = 1; i <= 3; i++) begin
            press(BTN_SELECT);
            check_stats(i % 3);
        end
        press(BTN_STATS);
        expect_mode_only();

        for (int s = 0; s < 5; s++) begin  // exit from every stage
            press(BTN_CONFIRM);
            expect_digit(1, SEG_TAB[cur_op + 1]);
            expect_digit(2, 8'h00);
            expect_digit(4, 8'h00);
            expect_digit(7, 8'h00);
            repeat (s) press(BTN_CONFIRM);
            press(BTN_EXIT);
            expect_mode_only();
        end

        $display("Test OK");
        $finish;
    end

endmodule

// File: build.f
+incdir+common
common/quiz_pkg.sv
hw/button_pacer.sv
quiz/quiz_control.sv
quiz/answer_unit.sv
quiz/quiz_tally.sv
display/frame_builder.sv
display/digit_scanner.sv
hw/study_top.sv
bench/study_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= study_tb
BUILD_DIR ?= obj_dir
FILELIST  ?= build.f
VFLAGS    ?= --binary -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard common/*.svh)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)
